// ==== filelist.f ====
hw/e300_glue_pkg.sv
hw/setting_decode.sv
hw/frontend_ctrl.sv
hw/button_irq.sv
hw/status_sync.sv
hw/readback_mux.sv
hw/e300_glue_top.sv
verification/e300_glue_sva.sv
verification/e300_glue_tb.sv

// ==== hw/button_irq.sv ====
// ------------------------------
// Power button press and release
// interrupts with pulse stretching
// ------------------------------

`timescale 1ns/1ps

module button_irq (
  input  logic bus_clk,
  input  logic bus_rst,
  // Debounced switch, low while pressed
  input  logic onswitch_n,
  output logic button_press_irq,
  output logic button_release_irq
);

  // Last two samples, [0] is the newest
  logic [1:0] sw_hist;

  logic press_det;
  logic release_det;

  logic [e300_glue_pkg::STRETCH_LEN-1:0] press_sr;
  logic [e300_glue_pkg::STRETCH_LEN-1:0] release_sr;

  // ------------------------------
  // Edge detection
  // ------------------------------
  // History starts at the idle level of the switch,
  // so leaving reset does not look like a release
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      sw_hist <= 2'b11;
    end else begin
      sw_hist <= {sw_hist[0], onswitch_n};
    end
  end

  // Two high samples then low is a press
  assign press_det   = ~onswitch_n & sw_hist[0] & sw_hist[1];
  assign release_det = onswitch_n & ~sw_hist[0] & ~sw_hist[1];

  // ------------------------------
  // Pulse stretch
  // ------------------------------
  // Each detection walks through the shift register,
  // keeping the interrupt up long enough not to be missed
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      press_sr   <= '0;
      release_sr <= '0;
    end else begin
      press_sr   <= {press_sr[e300_glue_pkg::STRETCH_LEN-2:0], press_det};
      release_sr <= {release_sr[e300_glue_pkg::STRETCH_LEN-2:0], release_det};
    end
  end

  assign button_press_irq   = |press_sr;
  assign button_release_irq = |release_sr;

endmodule

// ==== hw/e300_glue_pkg.sv ====
// ------------------------------
// Shared widths, field positions and register
// addresses for the board glue controller
// ------------------------------

package e300_glue_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int DATA_W = 32;
  localparam int ADDR_W = 8;

  // ------------------------------
  // Front-end control field
  // ------------------------------
  localparam int FE_W   = 9;
  localparam int FE_LSB = 10;

  // Bit order inside the field, from bit 0 upward
  localparam int FE_TX_EN_A      = 0;
  localparam int FE_TX_EN_B      = 1;
  localparam int FE_VCTXRX_V1    = 2;
  localparam int FE_VCTXRX_V2    = 3;
  localparam int FE_VCRX_V1      = 4;
  localparam int FE_VCRX_V2      = 5;
  localparam int FE_LED_RX       = 6;
  localparam int FE_LED_TXRX_RX  = 7;
  localparam int FE_LED_TXRX_TX  = 8;

  // Button interrupt length in bus cycles
  localparam int STRETCH_LEN = 8;

  // Synchronizer depths
  localparam int PPS_STAGES  = 3;
  localparam int SYNC_STAGES = 2;

  // PLL lock, 10 MHz present, PPS present, reference lock
  localparam int TCXO_W = 4;

  // Status word layout
  localparam int ST_PPS        = 0;
  localparam int ST_TCXO_LSB   = 1;
  localparam int ST_DRAM_ERR   = 5;
  localparam int ST_CALIB_DONE = 6;

  // Register map, REG_NONE marks an unmapped read
  typedef enum logic [ADDR_W-1:0] {
    REG_CTRL0  = 8'd0,
    REG_CTRL1  = 8'd1,
    REG_STATUS = 8'd2,
    REG_NONE   = 8'hff
  } reg_addr_e;

endpackage

// ==== hw/e300_glue_top.sv ====
// ------------------------------
// Board glue controller top level
// ------------------------------

`timescale 1ns/1ps

module e300_glue_top (
  input  logic                              bus_clk,
  input  logic                              bus_rst,
  // Settings write bus
  input  logic                              set_stb,
  input  logic [e300_glue_pkg::ADDR_W-1:0]  set_addr,
  input  logic [e300_glue_pkg::DATA_W-1:0]  set_data,
  // Readback bus
  input  logic                              rb_stb,
  input  logic [e300_glue_pkg::ADDR_W-1:0]  rb_addr,
  output logic [e300_glue_pkg::DATA_W-1:0]  rb_data,
  output logic                              rb_valid,
  // Board inputs
  input  logic                              onswitch_n,
  input  logic                              gps_pps,
  input  logic [e300_glue_pkg::TCXO_W-1:0]  tcxo_status_raw,
  input  logic                              dram_compare_error,
  input  logic                              dram_calib_done,
  // Front-end pins per channel
  output logic [e300_glue_pkg::FE_W-1:0]    fe_ch0,
  output logic [e300_glue_pkg::FE_W-1:0]    fe_ch1,
  // Interrupts
  output logic                              button_press_irq,
  output logic                              button_release_irq
);

  logic                              wr_ctrl0;
  logic                              wr_ctrl1;
  logic                              rd_valid;
  e300_glue_pkg::reg_addr_e          rd_sel;
  logic [e300_glue_pkg::DATA_W-1:0]  ctrl0;
  logic [e300_glue_pkg::DATA_W-1:0]  ctrl1;
  logic                              pps_sync;
  logic [e300_glue_pkg::TCXO_W-1:0]  tcxo_sync;
  logic                              dram_err;
  logic                              calib_done_sync;

  // ------------------------------
  // Bus decode and registers
  // ------------------------------
  setting_decode u_decode (
    .bus_clk  (bus_clk),
    .bus_rst  (bus_rst),
    .set_stb  (set_stb),
    .set_addr (set_addr),
    .rb_stb   (rb_stb),
    .rb_addr  (rb_addr),
    .wr_ctrl0 (wr_ctrl0),
    .wr_ctrl1 (wr_ctrl1),
    .rd_valid (rd_valid),
    .rd_sel   (rd_sel)
  );

  frontend_ctrl u_frontend (
    .bus_clk  (bus_clk),
    .bus_rst  (bus_rst),
    .wr_ctrl0 (wr_ctrl0),
    .wr_ctrl1 (wr_ctrl1),
    .set_data (set_data),
    .ctrl0    (ctrl0),
    .ctrl1    (ctrl1),
    .fe_ch0   (fe_ch0),
    .fe_ch1   (fe_ch1)
  );

  // ------------------------------
  // Events and status
  // ------------------------------
  button_irq u_button (
    .bus_clk            (bus_clk),
    .bus_rst            (bus_rst),
    .onswitch_n         (onswitch_n),
    .button_press_irq   (button_press_irq),
    .button_release_irq (button_release_irq)
  );

  status_sync u_status (
    .bus_clk            (bus_clk),
    .bus_rst            (bus_rst),
    .gps_pps            (gps_pps),
    .tcxo_status_raw    (tcxo_status_raw),
    .dram_compare_error (dram_compare_error),
    .dram_calib_done    (dram_calib_done),
    .pps_sync           (pps_sync),
    .tcxo_sync          (tcxo_sync),
    .dram_err           (dram_err),
    .calib_done_sync    (calib_done_sync)
  );

  // Readback result stage
  readback_mux u_readback (
    .bus_clk         (bus_clk),
    .bus_rst         (bus_rst),
    .rd_valid        (rd_valid),
    .rd_sel          (rd_sel),
    .ctrl0           (ctrl0),
    .ctrl1           (ctrl1),
    .pps_sync        (pps_sync),
    .tcxo_sync       (tcxo_sync),
    .dram_err        (dram_err),
    .calib_done_sync (calib_done_sync),
    .rb_data         (rb_data),
    .rb_valid        (rb_valid)
  );

endmodule

// ==== hw/frontend_ctrl.sv ====
// ------------------------------
// Channel control registers and the
// front-end enable, antenna and LED fields
// ------------------------------

`timescale 1ns/1ps

module frontend_ctrl (
  input  logic                              bus_clk,
  input  logic                              bus_rst,
  // Write enables from decode
  input  logic                              wr_ctrl0,
  input  logic                              wr_ctrl1,
  input  logic [e300_glue_pkg::DATA_W-1:0]  set_data,
  // Full control words for readback
  output logic [e300_glue_pkg::DATA_W-1:0]  ctrl0,
  output logic [e300_glue_pkg::DATA_W-1:0]  ctrl1,
  // Front-end fields, one per channel
  output logic [e300_glue_pkg::FE_W-1:0]    fe_ch0,
  output logic [e300_glue_pkg::FE_W-1:0]    fe_ch1
);

  // ------------------------------
  // Control words
  // ------------------------------
  // Channel 0 register
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      ctrl0 <= '0;
    end else if (wr_ctrl0) begin
      ctrl0 <= set_data;
    end
  end

  // Channel 1 register
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      ctrl1 <= '0;
    end else if (wr_ctrl1) begin
      ctrl1 <= set_data;
    end
  end

  // ------------------------------
  // Front-end fields
  // ------------------------------
  // Bits 18 down to 10 of each word, lowest bit first:
  //   TX enable A and B
  //   TX/RX antenna switch V1 and V2
  //   RX antenna switch V1 and V2
  //   RX LED, TX/RX LED in receive, TX/RX LED in transmit
  // Channel 0 drives the first set of pins, no swap
  assign fe_ch0 = ctrl0[e300_glue_pkg::FE_LSB +: e300_glue_pkg::FE_W];
  assign fe_ch1 = ctrl1[e300_glue_pkg::FE_LSB +: e300_glue_pkg::FE_W];

  // Remaining bits of each word are kept for
  // software but have no pin behind them

endmodule

// ==== hw/readback_mux.sv ====
// ------------------------------
// Status word packing and registered
// readback data
// ------------------------------

`timescale 1ns/1ps

module readback_mux (
  input  logic                              bus_clk,
  input  logic                              bus_rst,
  // From decode
  input  logic                              rd_valid,
  input  e300_glue_pkg::reg_addr_e          rd_sel,
  // Register sources
  input  logic [e300_glue_pkg::DATA_W-1:0]  ctrl0,
  input  logic [e300_glue_pkg::DATA_W-1:0]  ctrl1,
  input  logic                              pps_sync,
  input  logic [e300_glue_pkg::TCXO_W-1:0]  tcxo_sync,
  input  logic                              dram_err,
  input  logic                              calib_done_sync,
  // Readback bus
  output logic [e300_glue_pkg::DATA_W-1:0]  rb_data,
  output logic                              rb_valid
);

  logic [e300_glue_pkg::DATA_W-1:0] status_word;
  logic [e300_glue_pkg::DATA_W-1:0] rd_mux;

  // Unused status bits read zero
  always_comb begin
    status_word = '0;
    status_word[e300_glue_pkg::ST_PPS] = pps_sync;
    status_word[e300_glue_pkg::ST_TCXO_LSB +: e300_glue_pkg::TCXO_W] = tcxo_sync;
    status_word[e300_glue_pkg::ST_DRAM_ERR]   = dram_err;
    status_word[e300_glue_pkg::ST_CALIB_DONE] = calib_done_sync;
  end

  always_comb begin
    case (rd_sel)
      e300_glue_pkg::REG_CTRL0:  rd_mux = ctrl0;
      e300_glue_pkg::REG_CTRL1:  rd_mux = ctrl1;
      e300_glue_pkg::REG_STATUS: rd_mux = status_word;
      default:                   rd_mux = '0;
    endcase
  end

  // Second readback stage
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rb_valid <= 1'b0;
      rb_data  <= '0;
    end else begin
      rb_valid <= rd_valid;
      if (rd_valid) begin
        rb_data <= rd_mux;
      end
    end
  end

endmodule

// ==== hw/setting_decode.sv ====
// ------------------------------
// Settings bus decode: write enables and
// registered readback selection
// ------------------------------

`timescale 1ns/1ps

module setting_decode (
  input  logic                                bus_clk,
  input  logic                                bus_rst,
  // Write strobe bus
  input  logic                                set_stb,
  input  logic [e300_glue_pkg::ADDR_W-1:0]    set_addr,
  // Readback strobe bus
  input  logic                                rb_stb,
  input  logic [e300_glue_pkg::ADDR_W-1:0]    rb_addr,
  // To the control registers
  output logic                                wr_ctrl0,
  output logic                                wr_ctrl1,
  // To the readback stage
  output logic                                rd_valid,
  output e300_glue_pkg::reg_addr_e            rd_sel
);

  // ------------------------------
  // Write path
  // ------------------------------
  // One enable per writable register, same cycle as the strobe.
  // Status and unmapped addresses raise nothing
  always_comb begin
    wr_ctrl0 = 1'b0;
    wr_ctrl1 = 1'b0;
    if (set_stb) begin
      case (set_addr)
        e300_glue_pkg::REG_CTRL0: wr_ctrl0 = 1'b1;
        e300_glue_pkg::REG_CTRL1: wr_ctrl1 = 1'b1;
        default: ;
      endcase
    end
  end

  // ------------------------------
  // Read path
  // ------------------------------
  // First readback stage, one request accepted every cycle
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rd_valid <= 1'b0;
      rd_sel   <= e300_glue_pkg::REG_NONE;
    end else begin
      rd_valid <= rb_stb;
      if (rb_stb) begin
        case (rb_addr)
          e300_glue_pkg::REG_CTRL0,
          e300_glue_pkg::REG_CTRL1,
          e300_glue_pkg::REG_STATUS: rd_sel <= e300_glue_pkg::reg_addr_e'(rb_addr);
          default:                   rd_sel <= e300_glue_pkg::REG_NONE;
        endcase
      end
    end
  end

endmodule

// ==== hw/status_sync.sv ====
// ------------------------------
// Synchronizers for PPS, reference status
// and DRAM test flags, sticky DRAM error
// ------------------------------

`timescale 1ns/1ps

module status_sync (
  input  logic                              bus_clk,
  input  logic                              bus_rst,
  // Asynchronous inputs
  input  logic                              gps_pps,
  input  logic [e300_glue_pkg::TCXO_W-1:0]  tcxo_status_raw,
  input  logic                              dram_compare_error,
  input  logic                              dram_calib_done,
  // Bus clock domain
  output logic                              pps_sync,
  output logic [e300_glue_pkg::TCXO_W-1:0]  tcxo_sync,
  output logic                              dram_err,
  output logic                              calib_done_sync
);

  localparam int PN = e300_glue_pkg::PPS_STAGES;
  localparam int SN = e300_glue_pkg::SYNC_STAGES;

  logic [PN-1:0]                             pps_pipe;
  logic [SN-1:0][e300_glue_pkg::TCXO_W-1:0]  tcxo_pipe;
  logic [SN-1:0]                             err_pipe;
  logic [SN-1:0]                             calib_pipe;

  logic err_sync;

  // ------------------------------
  // Synchronizer chains
  // ------------------------------
  // Index 0 takes the raw input, the top index is the output
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      pps_pipe   <= '0;
      tcxo_pipe  <= '0;
      err_pipe   <= '0;
      calib_pipe <= '0;
    end else begin
      pps_pipe   <= {pps_pipe[PN-2:0], gps_pps};
      tcxo_pipe  <= {tcxo_pipe[SN-2:0], tcxo_status_raw};
      err_pipe   <= {err_pipe[SN-2:0], dram_compare_error};
      calib_pipe <= {calib_pipe[SN-2:0], dram_calib_done};
    end
  end

  assign pps_sync        = pps_pipe[PN-1];
  assign tcxo_sync       = tcxo_pipe[SN-1];
  assign err_sync        = err_pipe[SN-1];
  assign calib_done_sync = calib_pipe[SN-1];

  // ------------------------------
  // DRAM test monitor
  // ------------------------------
  // Compare errors before calibration are noise from the
  // controller start-up and are ignored. Once set, held
  // until reset
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      dram_err <= 1'b0;
    end else if (err_sync && calib_done_sync) begin
      dram_err <= 1'b1;
    end
  end

endmodule

// ==== verification/e300_glue_sva.sv ====
// ------------------------------
// Bound checks on readback timing, the
// sticky DRAM error and interrupt length
// ------------------------------

`timescale 1ns/1ps

module e300_glue_sva (
  input logic bus_clk,
  input logic bus_rst,
  input logic rb_stb,
  input logic rb_valid,
  input logic dram_err,
  input logic onswitch_n,
  input logic button_press_irq,
  input logic button_release_irq
);

  // Switch history with the newest sample in [0]
  logic [1:0] sw_seen;
  logic       press_seen;
  logic       release_seen;

  // Number of failed assertions so far
  int fail_count = 0;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      sw_seen <= 2'b11;
    end else begin
      sw_seen <= {sw_seen[0], onswitch_n};
    end
  end

  assign press_seen   = ~onswitch_n & sw_seen[0] & sw_seen[1];
  assign release_seen = onswitch_n & ~sw_seen[0] & ~sw_seen[1];

  // ------------------------------
  // Readback pipeline
  // ------------------------------
  rb_valid_after_stb: assert property (@(posedge bus_clk) disable iff (bus_rst)
    rb_stb |-> ##2 rb_valid)
    else begin
      fail_count++;
      $error("rb_valid missing after a readback strobe");
    end

  rb_valid_without_stb: assert property (@(posedge bus_clk) disable iff (bus_rst)
    !rb_stb |-> ##2 !rb_valid)
    else begin
      fail_count++;
      $error("rb_valid raised without a readback strobe");
    end

  // Only reset may clear the DRAM error flag
  dram_err_sticky: assert property (@(posedge bus_clk) disable iff (bus_rst)
    $fell(dram_err) |-> $past(bus_rst))
    else begin
      fail_count++;
      $error("dram_err fell outside reset");
    end

  // ------------------------------
  // Interrupt stretch bound
  // ------------------------------
  press_irq_len: assert property (@(posedge bus_clk) disable iff (bus_rst)
    (!press_seen)[*e300_glue_pkg::STRETCH_LEN] |=> !button_press_irq)
    else begin
      fail_count++;
      $error("button_press_irq held past its stretch length");
    end

  release_irq_len: assert property (@(posedge bus_clk) disable iff (bus_rst)
    (!release_seen)[*e300_glue_pkg::STRETCH_LEN] |=> !button_release_irq)
    else begin
      fail_count++;
      $error("button_release_irq held past its stretch length");
    end

endmodule

bind e300_glue_top e300_glue_sva u_sva (
  .bus_clk            (bus_clk),
  .bus_rst            (bus_rst),
  .rb_stb             (rb_stb),
  .rb_valid           (rb_valid),
  .dram_err           (dram_err),
  .onswitch_n         (onswitch_n),
  .button_press_irq   (button_press_irq),
  .button_release_irq (button_release_irq)
);

// ==== verification/e300_glue_tb.sv ====
// ------------------------------
// Table-driven testbench for the board
// glue controller
// ------------------------------

`timescale 1ns/1ps

module e300_glue_tb;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 8;
  localparam int STEP_CYCLES = 40;
  localparam int RB_TIMEOUT  = 10;
  localparam int STATUS_WAIT = 5;
  localparam int FW = e300_glue_pkg::FE_W;
  localparam int FL = e300_glue_pkg::FE_LSB;

  typedef enum {OP_OUTS, OP_WRITE, OP_READ, OP_READ_PAIR, OP_SWITCH, OP_STATUS} op_e;

  typedef struct {
    string       name;
    op_e         op;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] exp;
  } step_t;

  logic                              bus_clk;
  logic                              bus_rst;
  logic                              set_stb;
  logic [e300_glue_pkg::ADDR_W-1:0]  set_addr;
  logic [e300_glue_pkg::DATA_W-1:0]  set_data;
  logic                              rb_stb;
  logic [e300_glue_pkg::ADDR_W-1:0]  rb_addr;
  logic [e300_glue_pkg::DATA_W-1:0]  rb_data;
  logic                              rb_valid;
  logic                              onswitch_n;
  logic                              gps_pps;
  logic [e300_glue_pkg::TCXO_W-1:0]  tcxo_status_raw;
  logic                              dram_compare_error;
  logic                              dram_calib_done;
  logic [FW-1:0]                     fe_ch0;
  logic [FW-1:0]                     fe_ch1;
  logic                              button_press_irq;
  logic                              button_release_irq;

  step_t  steps[$];
  integer seed;
  logic   table_ready;

  e300_glue_top DUT (
    .bus_clk            (bus_clk),
    .bus_rst            (bus_rst),
    .set_stb            (set_stb),
    .set_addr           (set_addr),
    .set_data           (set_data),
    .rb_stb             (rb_stb),
    .rb_addr            (rb_addr),
    .rb_data            (rb_data),
    .rb_valid           (rb_valid),
    .onswitch_n         (onswitch_n),
    .gps_pps            (gps_pps),
    .tcxo_status_raw    (tcxo_status_raw),
    .dram_compare_error (dram_compare_error),
    .dram_calib_done    (dram_calib_done),
    .fe_ch0             (fe_ch0),
    .fe_ch1             (fe_ch1),
    .button_press_irq   (button_press_irq),
    .button_release_irq (button_release_irq)
  );

  always #(CLK_PERIOD / 2) bus_clk = ~bus_clk;

  // ------------------------------
  // Expected values and table helpers
  // ------------------------------
  // Front-end fields of both channels with channel 0 in the low bits
  function automatic logic [31:0] fe_pair(logic [31:0] c0, logic [31:0] c1);
    logic [31:0] r;
    r = '0;
    r[0 +: FW]  = c0[FL +: FW];
    r[FW +: FW] = c1[FL +: FW];
    return r;
  endfunction

  function automatic logic [31:0] status_exp(logic pps, logic [3:0] tcxo, logic err,
                                             logic calib);
    logic [31:0] r;
    r = '0;
    r[e300_glue_pkg::ST_PPS] = pps;
    r[e300_glue_pkg::ST_TCXO_LSB +: e300_glue_pkg::TCXO_W] = tcxo;
    r[e300_glue_pkg::ST_DRAM_ERR]   = err;
    r[e300_glue_pkg::ST_CALIB_DONE] = calib;
    return r;
  endfunction

  // Status input levels as carried in a step's data field
  function automatic logic [31:0] stat_drive(logic pps, logic [3:0] tcxo, logic err,
                                             logic calib);
    return {25'd0, calib, err, pps, tcxo};
  endfunction

  function automatic void add_step(string name, op_e op, logic [7:0] addr,
                                   logic [31:0] data, logic [31:0] exp);
    step_t s;
    s.name = name;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    steps.push_back(s);
  endfunction

  task automatic build_table();
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] fe;
    logic [3:0]  tc;
    w0 = $random(seed);
    w1 = $random(seed);
    w2 = $random(seed);
    fe = fe_pair(w0, w1);
    tc = 4'b1011;
    add_step("reset_outputs", OP_OUTS, 8'd0, 32'd0, 32'd0);
    add_step("reset_read_ctrl0", OP_READ, e300_glue_pkg::REG_CTRL0, 32'd0, 32'd0);
    add_step("write_ctrl0", OP_WRITE, e300_glue_pkg::REG_CTRL0, w0, fe_pair(w0, 32'd0));
    add_step("write_ctrl1", OP_WRITE, e300_glue_pkg::REG_CTRL1, w1, fe);
    add_step("read_ctrl_pair", OP_READ_PAIR, e300_glue_pkg::REG_CTRL0, w1, w0);
    add_step("write_status_ignored", OP_WRITE, e300_glue_pkg::REG_STATUS, w2, fe);
    add_step("write_unknown_ignored", OP_WRITE, 8'h5a, ~w0, fe);
    add_step("read_pair_unchanged", OP_READ_PAIR, e300_glue_pkg::REG_CTRL0, w1, w0);
    add_step("read_unknown", OP_READ, 8'h77, 32'd0, 32'd0);
    add_step("press_irq_len", OP_SWITCH, 8'd20, 32'd0, e300_glue_pkg::STRETCH_LEN);
    add_step("release_irq_len", OP_SWITCH, 8'd20, 32'd1, e300_glue_pkg::STRETCH_LEN);
    add_step("pps_tcxo_in", OP_STATUS, 8'd0, stat_drive(1'b1, tc, 1'b0, 1'b0), 32'd0);
    add_step("status_pps_tcxo", OP_READ, e300_glue_pkg::REG_STATUS, 32'd0,
             status_exp(1'b1, tc, 1'b0, 1'b0));
    add_step("err_early_in", OP_STATUS, 8'd0, stat_drive(1'b1, tc, 1'b1, 1'b0), 32'd0);
    add_step("dram_err_before_calib", OP_READ, e300_glue_pkg::REG_STATUS, 32'd0,
             status_exp(1'b1, tc, 1'b0, 1'b0));
    add_step("calib_in", OP_STATUS, 8'd0, stat_drive(1'b1, tc, 1'b0, 1'b1), 32'd0);
    add_step("calib_done", OP_READ, e300_glue_pkg::REG_STATUS, 32'd0,
             status_exp(1'b1, tc, 1'b0, 1'b1));
    add_step("err_in", OP_STATUS, 8'd0, stat_drive(1'b1, tc, 1'b1, 1'b1), 32'd0);
    add_step("dram_err_set", OP_READ, e300_glue_pkg::REG_STATUS, 32'd0,
             status_exp(1'b1, tc, 1'b1, 1'b1));
    add_step("err_drop_in", OP_STATUS, 8'd0, stat_drive(1'b1, tc, 1'b0, 1'b1), 32'd0);
    add_step("dram_err_sticky", OP_READ, e300_glue_pkg::REG_STATUS, 32'd0,
             status_exp(1'b1, tc, 1'b1, 1'b1));
  endtask

  // ------------------------------
  // Checks and bus tasks
  // ------------------------------
  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic wait_valid(string name);
    int n;
    n = 0;
    do begin
      @(negedge bus_clk);
      n++;
    end while (!rb_valid && n < RB_TIMEOUT);
    assert (rb_valid) else begin
      $display("%s: rb_valid never rose after the read strobe", name);
      $display("RESULT: FAIL");
      $fatal(1, "readback timeout in %s", name);
    end
  endtask

  task automatic run_step(step_t s);
    int cnt;
    cnt = 0;
    case (s.op)
      OP_OUTS: begin
        @(negedge bus_clk);
        check_val(s.name, s.exp,
                  {button_release_irq, button_press_irq, rb_valid, fe_ch1, fe_ch0});
      end
      OP_WRITE: begin
        @(posedge bus_clk);
        set_stb  <= 1'b1;
        set_addr <= s.addr;
        set_data <= s.data;
        @(posedge bus_clk);
        set_stb  <= 1'b0;
        @(negedge bus_clk);
        check_val(s.name, s.exp, {fe_ch1, fe_ch0});
      end
      OP_READ: begin
        @(posedge bus_clk);
        rb_stb  <= 1'b1;
        rb_addr <= s.addr;
        @(posedge bus_clk);
        rb_stb  <= 1'b0;
        wait_valid(s.name);
        check_val(s.name, s.exp, rb_data);
      end
      OP_READ_PAIR: begin
        // Two strobes on consecutive edges give back to back results
        @(posedge bus_clk);
        rb_stb  <= 1'b1;
        rb_addr <= s.addr;
        @(posedge bus_clk);
        rb_addr <= s.addr + 8'd1;
        @(posedge bus_clk);
        rb_stb  <= 1'b0;
        wait_valid(s.name);
        check_val(s.name, s.exp, rb_data);
        @(negedge bus_clk);
        check_val({s.name, "_second_valid"}, 32'd1, rb_valid);
        check_val({s.name, "_second"}, s.data, rb_data);
      end
      OP_SWITCH: begin
        // Low level presses the switch and high releases it
        @(posedge bus_clk);
        onswitch_n <= s.data[0];
        repeat (s.addr) begin
          @(negedge bus_clk);
          if (s.data[0] ? button_release_irq : button_press_irq) begin
            cnt++;
          end
        end
        check_val(s.name, s.exp, cnt);
      end
      OP_STATUS: begin
        @(posedge bus_clk);
        tcxo_status_raw    <= s.data[3:0];
        gps_pps            <= s.data[4];
        dram_compare_error <= s.data[5];
        dram_calib_done    <= s.data[6];
        repeat (STATUS_WAIT) @(posedge bus_clk);
      end
      default: ;
    endcase
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    table_ready        = 1'b0;
    bus_clk            = 1'b0;
    bus_rst            = 1'b1;
    set_stb            = 1'b0;
    set_addr           = '0;
    set_data           = '0;
    rb_stb             = 1'b0;
    rb_addr            = '0;
    onswitch_n         = 1'b1;
    gps_pps            = 1'b0;
    tcxo_status_raw    = '0;
    dram_compare_error = 1'b0;
    dram_calib_done    = 1'b0;
    seed               = 24329;
    build_table();
    table_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge bus_clk);
    bus_rst <= 1'b0;
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    $display("RESULT: PASS");
    $finish;
  end

  // Bound checker on the DUT
  initial begin
    wait (DUT.u_sva.fail_count != 0);
    $display("A bound assertion on the DUT failed");
    $display("RESULT: FAIL");
    $fatal(1, "assertion failure");
  end

  initial begin
    wait (table_ready === 1'b1);
    #(steps.size() * STEP_CYCLES * CLK_PERIOD);
    $display("Timeout: the step table did not complete in the allowed time");
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule
